// ==== src/tag_pkg.sv ====
/*
 * tag capture shared definitions
 * sizes, the fixed tag code table, record types and the writer state
 */

`default_nettype none

package tag_pkg;

  //////////////////////////////////////////////////////////////////////////
  // sizes

  localparam int num_channels    = 4;
  localparam int channel_width   = 16;
  localparam int data_width      = num_channels * channel_width;
  localparam int num_tags        = 8;
  localparam int read_width      = 16;
  localparam int reads_per_entry = data_width / read_width;
  localparam int fifo_depth      = 16;
  localparam int fifo_addr_width = $clog2(fifo_depth);
  localparam int hw_idx_width    = $clog2(reads_per_entry);

  // tag code i sets bit i of the hit mask
  localparam logic [channel_width-1:0] tag_codes [num_tags] = '{
    16'ha5a5, 16'h1234, 16'hbeef, 16'hcafe,
    16'h0f0f, 16'h7e57, 16'hdead, 16'h5a5a
  };

  //////////////////////////////////////////////////////////////////////////
  // types

  typedef logic [num_tags-1:0] tag_mask_t;

  // channel 0 in the low halfword
  typedef struct packed {
    logic [num_channels-1:0][channel_width-1:0] ch;
  } sample_set_t;

  typedef struct packed {
    sample_set_t samples;
    tag_mask_t   mask;
  } tag_record_t;

  // two fifo writes per record
  typedef enum logic {
    wr_sample,
    wr_tags
  } wr_state_t;

endpackage

`default_nettype wire

// ==== src/tag_matcher.sv ====
/*
 * tag matcher
 * compares four channel samples against the tag code table and
 * registers each sample set together with its hit mask
 */

`timescale 1ns/1ps
`default_nettype none

module tag_matcher
  import tag_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,

  // sample input
  input  wire logic        sample_valid,
  output logic             sample_ready,
  input  wire sample_set_t sample,

  // record output
  output logic             rec_valid,
  input  wire logic        rec_ready,
  output tag_record_t      rec
);

  tag_mask_t   hit_mask;
  tag_record_t rec_q;
  logic        rec_valid_q;
  logic        sample_fire;

  ////////////////////////////////////////////////////////////////////////////
  // match logic

  // one comparator per channel and tag, hits ORed per tag
  always_comb begin
    hit_mask = '0;
    for (int t = 0; t < num_tags; t++) begin
      for (int c = 0; c < num_channels; c++) begin
        if (sample.ch[c] == tag_codes[t]) begin
          hit_mask[t] = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output stage

  // stage accepts when empty or draining this cycle
  assign sample_ready = ~rec_valid_q | rec_ready;
  assign sample_fire  = sample_valid & sample_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rec_valid_q <= 1'b0;
    end else if (sample_ready) begin
      rec_valid_q <= sample_valid;
    end
  end

  // payload only loads on a transfer, held under back-pressure
  always_ff @(posedge clk) begin
    if (sample_fire) begin
      rec_q.samples <= sample;
      rec_q.mask    <= hit_mask;
    end
  end

  assign rec_valid = rec_valid_q;
  assign rec       = rec_q;

endmodule

`default_nettype wire

// ==== src/narrow_read_fifo.sv ====
/*
 * narrow read fifo
 * 64-bit entries written whole, read back as four 16-bit halfwords
 * through a registered read port, low halfword first
 */

`timescale 1ns/1ps
`default_nettype none

module narrow_read_fifo
  import tag_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // write side
  input  wire logic                  wr_en,
  input  wire logic [data_width-1:0] wr_data,
  output logic                       free_two,

  // read side
  input  wire logic                  rd_en,
  output logic      [read_width-1:0] rd_data,
  output logic                       empty
);

  logic [data_width-1:0]      mem [fifo_depth];
  logic [fifo_addr_width-1:0] wr_ptr;
  logic [fifo_addr_width-1:0] rd_ptr;
  logic [hw_idx_width-1:0]    hw_idx;
  logic [fifo_addr_width:0]   count;
  logic                       wr_en_d;
  logic                       last_hw;
  logic                       entry_done;

  ////////////////////////////////////////////////////////////////////////////
  // storage

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers and occupancy

  assign last_hw    = (hw_idx == hw_idx_width'(reads_per_entry - 1));
  assign entry_done = rd_en & last_hw;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      hw_idx  <= '0;
      count   <= '0;
      wr_en_d <= 1'b0;
    end else begin
      wr_en_d <= wr_en;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        hw_idx <= hw_idx + 1'b1;
      end
      // entry retires after its fourth halfword
      if (entry_done) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, entry_done})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // registered halfword, holds between pops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_ptr][hw_idx*read_width +: read_width];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // flags

  // newest entry stays hidden from the reader for one cycle
  assign empty    = (count == {{fifo_addr_width{1'b0}}, wr_en_d});
  assign free_two = (count <= (fifo_addr_width + 1)'(fifo_depth - 2));

endmodule

`default_nettype wire

// ==== src/tag_data_buff.sv ====
/*
 * tag data buffer
 * writes each record as a sample entry then a tag entry, and turns the
 * microprocessor read strobe into single 16-bit pops
 */

`timescale 1ns/1ps
`default_nettype none

module tag_data_buff
  import tag_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,

  // record input
  input  wire logic        rec_valid,
  output logic             rec_ready,
  input  wire tag_record_t rec,

  // microprocessor side
  input  wire logic        rd_ena,
  output logic             ready,
  output logic [read_width-1:0] data_out
);

  wr_state_t             wr_state;
  tag_mask_t             mask_q;
  logic                  rec_fire;
  logic                  fifo_wr_en;
  logic [data_width-1:0] fifo_wr_data;
  logic                  fifo_free_two;
  logic                  fifo_empty;
  logic                  rd_ena_d;
  logic                  pop;

  ////////////////////////////////////////////////////////////////////////////
  // writer

  // no new record while the tag word goes in, or without room for both
  assign rec_ready = (wr_state == wr_sample) & fifo_free_two;
  assign rec_fire  = rec_valid & rec_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state <= wr_sample;
    end else begin
      case (wr_state)
        wr_sample: if (rec_fire) wr_state <= wr_tags;
        wr_tags:   wr_state <= wr_sample;
        default:   wr_state <= wr_sample;
      endcase
    end
  end

  // mask waits here for the second write
  always_ff @(posedge clk) begin
    if (rec_fire) begin
      mask_q <= rec.mask;
    end
  end

  assign fifo_wr_en   = rec_fire | (wr_state == wr_tags);
  // tag word is the mask zero-extended
  assign fifo_wr_data = (wr_state == wr_tags) ?
                        {{(data_width - num_tags){1'b0}}, mask_q} : rec.samples;

  ////////////////////////////////////////////////////////////////////////////
  // reader

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ena_d <= 1'b0;
    end else begin
      rd_ena_d <= rd_ena;
    end
  end

  // rising strobe only
  assign pop = rd_ena & ~rd_ena_d & ~fifo_empty;

  narrow_read_fifo i_narrow_read_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (fifo_wr_en),
    .wr_data  (fifo_wr_data),
    .free_two (fifo_free_two),
    .rd_en    (pop),
    .rd_data  (data_out),
    .empty    (fifo_empty)
  );

  assign ready = ~fifo_empty;

endmodule

`default_nettype wire

// ==== src/tag_capture_top.sv ====
/*
 * tag capture top level
 * tag matcher feeding the serializing buffer read by the microprocessor
 */

`timescale 1ns/1ps
`default_nettype none

module tag_capture_top
  import tag_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,

  // sample input
  input  wire logic        sample_valid,
  output logic             sample_ready,
  input  wire sample_set_t sample,

  // microprocessor side
  input  wire logic        rd_ena,
  output logic             ready,
  output logic [read_width-1:0] data_out
);

  ////////////////////////////////////////////////////////////////////////////
  // matcher to buffer

  logic        rec_valid;
  logic        rec_ready;
  tag_record_t rec;

  tag_matcher i_tag_matcher (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sample       (sample),
    .rec_valid    (rec_valid),
    .rec_ready    (rec_ready),
    .rec          (rec)
  );

  tag_data_buff i_tag_data_buff (
    .clk       (clk),
    .rst_n     (rst_n),
    .rec_valid (rec_valid),
    .rec_ready (rec_ready),
    .rec       (rec),
    .rd_ena    (rd_ena),
    .ready     (ready),
    .data_out  (data_out)
  );

endmodule

`default_nettype wire

// ==== tb/tag_capture_chk.sv ====
/*
 * tag data buffer checker
 * handshake and read strobe properties, bound into the buffer
 */

`timescale 1ns/1ps
`default_nettype none

module tag_capture_chk
  import tag_pkg::*;
(
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  rec_valid,
  input wire logic                  rec_ready,
  input wire tag_record_t           rec,
  input wire wr_state_t             wr_state,
  input wire logic                  rd_ena,
  input wire logic [read_width-1:0] data_out
);

  int fail_count = 0;

  // record held under back-pressure
  rec_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    rec_valid && !rec_ready |=> rec_valid && $stable(rec))
    else begin
      $error("rec_valid or rec changed while rec_ready was low");
      fail_count++;
    end

  // a transfer moves the writer to wr_tags, which blocks the next record
  tags_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    rec_valid && rec_ready |=> wr_state == wr_tags && !rec_ready)
    else begin
      $error("writer not in wr_tags with rec_ready low after a transfer");
      fail_count++;
    end

  // data_out moves only after a rising strobe
  pop_edge_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_ena && !$past(rd_ena)) |=> $stable(data_out))
    else begin
      $error("data_out changed without a rising rd_ena");
      fail_count++;
    end

endmodule

bind tag_data_buff tag_capture_chk i_tag_capture_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .rec_valid (rec_valid),
  .rec_ready (rec_ready),
  .rec       (rec),
  .wr_state  (wr_state),
  .rd_ena    (rd_ena),
  .data_out  (data_out)
);

`default_nettype wire

// ==== tb/tag_capture_tb.sv ====
/*
 * tag capture testbench
 * replays the golden records through the sample handshake and reads
 * every halfword back through the microprocessor read strobe
 */

`timescale 1ns/1ps
`default_nettype none

module tag_capture_tb
  import tag_pkg::*;
();

  localparam int clk_period        = 40;
  localparam int reset_cycles      = 10;
  localparam int golden_cols       = 6;
  localparam int max_records       = 32;
  localparam int mode_fill         = 1;
  localparam int mode_strobe       = 2;
  localparam int mode_end          = 15;
  localparam int normal_hold       = 3;
  localparam int strobe_hold       = 24;
  localparam int wait_limit        = 64;
  localparam int cycles_per_record = 40;
  localparam int margin_cycles     = 400;
  // two fifo entries per record
  localparam int buffer_records    = fifo_depth / 2;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  sample_valid;
  logic                  sample_ready;
  sample_set_t           sample;
  logic                  rd_ena;
  logic                  ready;
  logic [read_width-1:0] data_out;

  // mode, ch0..ch3, mask per golden line
  logic [15:0] golden_mem [golden_cols * max_records];
  int          rec_mode    [max_records];
  sample_set_t rec_samples [max_records];
  tag_mask_t   rec_mask    [max_records];
  int          num_records;
  logic        golden_loaded = 1'b0;

  tag_capture_top i_tag_capture_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sample       (sample),
    .rd_ena       (rd_ena),
    .ready        (ready),
    .data_out     (data_out)
  );

  always #(clk_period / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // checks

  task automatic halt_with_failure();
    $display("Regression failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      halt_with_failure();
    end
  endtask

  task automatic check_word(input string name, input logic [read_width-1:0] got,
                            input logic [read_width-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      halt_with_failure();
    end
  endtask

  task automatic check_mask(input string name, input tag_mask_t got, input tag_mask_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      halt_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // golden data

  task automatic load_golden();
    int   base;
    logic found_end;
    found_end   = 1'b0;
    num_records = 0;
    $readmemh("tb/tag_capture_golden.txt", golden_mem);
    for (int r = 0; r < max_records && !found_end; r++) begin
      base = r * golden_cols;
      if (int'(golden_mem[base]) == mode_end) begin
        found_end = 1'b1;
      end else begin
        rec_mode[r] = int'(golden_mem[base]);
        for (int c = 0; c < num_channels; c++) begin
          rec_samples[r].ch[c] = golden_mem[base + 1 + c];
        end
        rec_mask[r] = golden_mem[base + golden_cols - 1][num_tags-1:0];
        num_records++;
      end
    end
    if (!found_end || num_records == 0) begin
      $display("golden file is empty or has no end line");
      halt_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks

  // valid held until the matcher takes the sample
  task automatic send_sample(input sample_set_t s);
    int waited;
    waited = 0;
    @(posedge clk);
    sample_valid <= 1'b1;
    sample       <= s;
    @(negedge clk);
    while (sample_ready !== 1'b1) begin
      if (waited == wait_limit) begin
        $display("sample_ready stayed low, sample never accepted");
        halt_with_failure();
      end
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    sample_valid <= 1'b0;
  endtask

  // one strobe, one halfword; hold sets how long rd_ena stays high
  task automatic read_word(input int hold, output logic [read_width-1:0] word);
    int waited;
    waited = 0;
    @(negedge clk);
    while (ready !== 1'b1) begin
      if (waited == wait_limit) begin
        $display("ready stayed low while a halfword was expected");
        halt_with_failure();
      end
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    rd_ena <= 1'b1;
    repeat (hold) @(posedge clk);
    @(negedge clk);
    word = data_out;
    @(posedge clk);
    rd_ena <= 1'b0;
  endtask

  // sample entry channel 0 first, then the zero-extended tag entry
  task automatic read_record(input int r, input int first_hold);
    logic [read_width-1:0] word;
    for (int c = 0; c < num_channels; c++) begin
      read_word((c == 0) ? first_hold : normal_hold, word);
      check_word($sformatf("data_out ch%0d rec %0d", c, r), word, rec_samples[r].ch[c]);
    end
    read_word(normal_hold, word);
    check_mask($sformatf("data_out mask rec %0d", r), word[num_tags-1:0], rec_mask[r]);
    check_word($sformatf("data_out tag hw0 rec %0d", r), word,
               {{(read_width - num_tags){1'b0}}, rec_mask[r]});
    for (int h = 1; h < reads_per_entry; h++) begin
      read_word(normal_hold, word);
      check_word($sformatf("data_out tag hw%0d rec %0d", h, r), word, '0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin : stimulus
    int r;
    int n;
    rst_n        <= 1'b0;
    sample_valid <= 1'b0;
    sample       <= '0;
    rd_ena       <= 1'b0;
    load_golden();
    golden_loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    // idle state right after reset
    @(negedge clk);
    check_bit("ready", ready, 1'b0);
    check_bit("sample_ready", sample_ready, 1'b1);
    check_word("data_out", data_out, '0);

    r = 0;
    while (r < num_records) begin
      if (rec_mode[r] == mode_fill) begin
        // fill burst, nothing read until all are sent
        n = 0;
        while (r + n < num_records && rec_mode[r + n] == mode_fill) begin
          n++;
        end
        for (int k = 0; k < n; k++) begin
          send_sample(rec_samples[r + k]);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit("ready", ready, 1'b1);
        // full buffer plus one record parked in the matcher
        check_bit("sample_ready", sample_ready, (n > buffer_records) ? 1'b0 : 1'b1);
        for (int k = 0; k < n; k++) begin
          read_record(r + k, normal_hold);
        end
        r += n;
      end else begin
        send_sample(rec_samples[r]);
        read_record(r, (rec_mode[r] == mode_strobe) ? strobe_hold : normal_hold);
        r++;
      end
      // buffer drained
      @(negedge clk);
      check_bit("ready", ready, 1'b0);
      check_bit("sample_ready", sample_ready, 1'b1);
    end

    if (i_tag_capture_top.i_tag_data_buff.i_tag_capture_chk.fail_count != 0) begin
      $display("concurrent assertions in the buffer checker failed");
      halt_with_failure();
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  // first failing buffer assertion ends the run
  initial begin : assertion_watch
    wait (i_tag_capture_top.i_tag_data_buff.i_tag_capture_chk.fail_count != 0);
    $display("a concurrent assertion in the buffer checker failed");
    halt_with_failure();
  end

  // bound by the number of golden records
  initial begin : watchdog
    wait (golden_loaded);
    repeat (reset_cycles + num_records * cycles_per_record + margin_cycles) @(posedge clk);
    $display("watchdog expired before all records were read back");
    halt_with_failure();
  end

endmodule

`default_nettype wire

// ==== tb/tag_capture_golden.txt ====
// columns: mode ch0 ch1 ch2 ch3 mask (hex)
// mode 0 single record, 1 fill burst without reads, 2 long strobe, f end
0 0001 0002 0003 0004 00
0 a5a5 1111 2222 3333 01
0 4444 5555 6666 5a5a 80
0 beef cafe 0f0f 7e57 3c
0 dead 0000 dead dead 40
0 1234 1234 a5a5 ffff 03
0 a5a4 1235 beee cafd 00
1 1000 1001 1002 1003 00
1 cafe 2001 2002 2003 08
1 3000 dead 3002 3003 40
1 4000 4001 0f0f 4003 10
1 5000 5001 5002 7e57 20
1 6000 beef 1234 6003 06
1 7000 7001 7002 7003 00
1 5a5a 8001 a5a5 8003 81
1 9000 9001 9002 cafe 08
2 beef 00aa 1234 00bb 06
f 0000 0000 0000 0000 00

// ==== tag_capture.f ====
src/tag_pkg.sv
src/tag_matcher.sv
src/narrow_read_fifo.sv
src/tag_data_buff.sv
src/tag_capture_top.sv
tb/tag_capture_chk.sv
tb/tag_capture_tb.sv

// ==== Makefile ====
# Verilator build and run for the tag capture testbench

VERILATOR ?= verilator
TOP       ?= tag_capture_tb
FILELIST  ?= tag_capture.f
OBJ_DIR   ?= ./obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Regression passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out=$$($(SIM_BIN) $(SIM_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
